// ==== Makefile ====
TOP = cache_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f compile.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
verilog/cache_pkg.sv
verilog/cache_cmd_if.sv
verilog/cache_controller.sv
verilog/cache_datapath.sv
verilog/cache_top.sv
verif/cache_tb.sv

// ==== verif/cache_cases.txt ====
# Columns: op addr data, op is R read, W write or F flush
# addr and data are hex, a flush ignores both
# Cold read, then hits on the same line
R 00001040 00000000
R 00001044 00000000
W 00001048 DEADBEEF
R 00001048 00000000
R 0000104C 00000000
# Same index, new tag, dirty victim goes out first
R 00002040 00000000
R 00001048 00000000
# Clean eviction
R 00003044 00000000
# Write allocate, later evicted with the merged word
W 00005208 CAFEF00D
R 0000520C 00000000
R 00007200 00000000
W 000073F4 13579BDF
W 12345000 0BADF00D
W FFFFFFFC A5A5A5A5
R FFFFFFF0 00000000
F 00000000 00000000
# Lines held before the flush miss again
R 000073F4 00000000
R 12345000 00000000
W 00001040 11112222
F 00000000 00000000
F 00000000 00000000
W 00008040 0F0F0F0F
R 00009040 00000000
R 00008040 00000000

// ==== verif/cache_tb.sv ====
`timescale 1ns/10ps

module cache_tb
    import cache_pkg::*;
();

    logic   clk = 1'b0;
    logic   rst;
    logic   cpu_req_i;
    logic   cpu_we_i;
    addr_t  cpu_addr_i;
    word_t  cpu_wdata_i;
    word_t  cpu_rdata_o;
    logic   cpu_ready_o;
    logic   flush_req_i;
    logic   flush_done_o;
    logic   mem_req_o;
    logic   mem_we_o;
    addr_t  mem_addr_o;
    line_t  mem_wdata_o;
    line_t  mem_rdata_i;
    logic   mem_ack_i;

    // Cases from the data file
    logic [7:0] op_q   [$];
    addr_t      addr_q [$];
    word_t      data_q [$];

    // Reference cache and its own view of main memory
    logic [LINES-1:0] ref_valid;
    logic [LINES-1:0] ref_dirty;
    tag_t             ref_tag  [0:LINES-1];
    line_t            ref_data [0:LINES-1];
    line_t            ref_mem  [addr_t];

    line_t            mem_store [addr_t];   // Memory model contents

    // Predicted and observed memory transfers in order
    logic   exp_we   [$];
    addr_t  exp_addr [$];
    line_t  exp_line [$];
    logic   got_we   [$];
    addr_t  got_addr [$];
    line_t  got_line [$];

    int         cycle_cnt;
    int         cycle_limit = 0;
    int         done_pulses = 0;
    int         flush_seen  = 0;
    int         n_flush     = 0;
    int         fd;
    int         i;
    string      text;
    logic [7:0] op;
    addr_t      a;
    word_t      d;
    logic       busy;
    int         wait_cycles;

    cache_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req_i),
        .cpu_we_i     (cpu_we_i),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .cpu_ready_o  (cpu_ready_o),
        .flush_req_i  (flush_req_i),
        .flush_done_o (flush_done_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ack_i    (mem_ack_i)
    );

    always #50 clk = ~clk;

    always @(negedge clk)
        if (flush_done_o)
            done_pulses++;

    // Initial memory contents with every word different
    function automatic line_t pattern_line(input addr_t la);
        line_t l;
        word_t wa;
        for (int w = 0; w < 4; w++)
        begin
            wa = {la[31:4], w[1:0], 2'b00};
            l[w*32 +: 32] = (wa * 32'h9E37_79B1) ^ 32'hC0DE_5EED;  // Odd multiplier
        end
        return l;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Error at %0d ns: %s expected %b got %b",
                                $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("Error at %0d ns: %s expected %h got %h",
                                $time, name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            abort_run($sformatf("Error at %0d ns: %s expected %h got %h",
                                $time, name, exp, act));
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp)
            abort_run($sformatf("Error at %0d ns: %s expected %h got %h",
                                $time, name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("Error at %0d ns: %s expected %0d got %0d",
                                $time, name, exp, act));
    endtask

    task automatic push_exp(input logic we, input addr_t la, input line_t l);
        exp_we.push_back(we);
        exp_addr.push_back(la);
        exp_line.push_back(l);
    endtask

    task automatic load_cases();
        int n;
        fd = $fopen("verif/cache_cases.txt", "r");
        if (fd == 0)
            abort_run("Could not open the case file verif/cache_cases.txt");
        while (!$feof(fd))
        begin
            text = "";
            n = $fgets(text, fd);
            if (text.len() < 3 || text.getc(0) == "#")
                continue;   // Blank or comment line
            n = $sscanf(text, "%c %h %h", op, a, d);
            if (n != 3)
                abort_run($sformatf("Case file line could not be read: %s", text));
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            if (op == "F")
                n_flush++;
        end
        $fclose(fd);
    endtask

    // Reference lookup with write-back before refill and merge
    task automatic predict_access(input logic we, input addr_t addr, input word_t wdata,
                                  output logic hit, output word_t rdata);
        index_t idx;
        tag_t   tg;
        int     w;
        addr_t  la;
        idx = addr[11:4];
        tg  = addr[31:12];
        w   = int'(addr[3:2]);
        hit = ref_valid[idx] && (ref_tag[idx] == tg);
        if (!hit)
        begin
            if (ref_valid[idx] && ref_dirty[idx])
            begin
                la = {ref_tag[idx], idx, 4'h0};
                push_exp(1'b1, la, ref_data[idx]);
                ref_mem[la] = ref_data[idx];
            end
            la = {tg, idx, 4'h0};
            ref_data[idx] = ref_mem.exists(la) ? ref_mem[la] : pattern_line(la);
            push_exp(1'b0, la, '0);
            ref_valid[idx] = 1'b1;
            ref_dirty[idx] = 1'b0;
            ref_tag[idx]   = tg;
        end
        if (we)
        begin
            ref_data[idx][w*32 +: 32] = wdata;
            ref_dirty[idx] = 1'b1;
        end
        rdata = ref_data[idx][w*32 +: 32];
    endtask

    task automatic check_mem_events();
        check_count("memory transfers", exp_addr.size(), got_addr.size());
        for (int k = 0; k < exp_addr.size(); k++)
        begin
            check_bit("mem_we_o", exp_we[k], got_we[k]);
            check_addr("mem_addr_o", exp_addr[k], got_addr[k]);
            if (exp_we[k])
                check_line("mem_wdata_o", exp_line[k], got_line[k]);
        end
        exp_we.delete();
        exp_addr.delete();
        exp_line.delete();
        got_we.delete();
        got_addr.delete();
        got_line.delete();
    endtask

    task automatic do_access(input logic we, input addr_t addr, input word_t wdata);
        logic  hit;
        word_t exp_rdata;
        int    cycles;
        logic  seen;
        predict_access(we, addr, wdata, hit, exp_rdata);
        @(posedge clk);
        cpu_req_i   <= 1'b1;
        cpu_we_i    <= we;
        cpu_addr_i  <= addr;
        cpu_wdata_i <= wdata;
        cycles = 0;
        seen   = 1'b0;
        while (!seen)
        begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            seen = cpu_ready_o;
        end
        if (!we)
            check_word("cpu_rdata_o", exp_rdata, cpu_rdata_o);
        if (hit)
            check_count("hit latency in cycles", 2, cycles);
        @(posedge clk);
        cpu_req_i <= 1'b0;
        cpu_we_i  <= 1'b0;
        check_mem_events();
    endtask

    task automatic do_flush();
        logic  seen;
        addr_t la;
        // Walk goes up from index 0
        for (int k = 0; k < LINES; k++)
        begin
            if (ref_valid[k] && ref_dirty[k])
            begin
                la = {ref_tag[k], index_t'(k), 4'h0};
                push_exp(1'b1, la, ref_data[k]);
                ref_mem[la] = ref_data[k];
            end
        end
        ref_valid = '0;
        ref_dirty = '0;
        @(posedge clk);
        flush_req_i <= 1'b1;
        @(posedge clk);
        flush_req_i <= 1'b0;   // One-cycle pulse
        seen = 1'b0;
        while (!seen)
        begin
            @(negedge clk);
            seen = flush_done_o;
        end
        flush_seen++;
        @(posedge clk);
        @(posedge clk);   // Pulse counter has sampled the cycle after done
        check_count("flush_done_o pulses", flush_seen, done_pulses);
        check_mem_events();
    endtask

    // Main memory model with a random answer delay
    initial
    begin
        void'($urandom(67));
        mem_ack_i   <= 1'b0;
        mem_rdata_i <= '0;
        busy        = 1'b0;
        wait_cycles = 0;
        forever
        begin
            @(posedge clk);
            if (mem_ack_i)
            begin
                mem_ack_i <= 1'b0;
                busy = 1'b0;
            end
            else if (mem_req_o)
            begin
                if (!busy)
                begin
                    busy = 1'b1;
                    wait_cycles = $urandom_range(0, 5);
                end
                if (wait_cycles > 0)
                    wait_cycles--;
                else
                begin
                    got_we.push_back(mem_we_o);
                    got_addr.push_back(mem_addr_o);
                    if (mem_we_o)
                    begin
                        got_line.push_back(mem_wdata_o);
                        mem_store[mem_addr_o] = mem_wdata_o;
                    end
                    else
                    begin
                        got_line.push_back('0);
                        mem_rdata_i <= mem_store.exists(mem_addr_o) ?
                                       mem_store[mem_addr_o] : pattern_line(mem_addr_o);
                    end
                    mem_ack_i <= 1'b1;
                end
            end
        end
    end

    initial
    begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the cases did not finish within %0d clock cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1, "Run stopped on timeout");
    end

    initial
    begin
        rst         <= 1'b0;
        cpu_req_i   <= 1'b0;
        cpu_we_i    <= 1'b0;
        cpu_addr_i  <= '0;
        cpu_wdata_i <= '0;
        flush_req_i <= 1'b0;
        ref_valid   = '0;
        ref_dirty   = '0;
        load_cases();
        cycle_limit = op_q.size() * 40 + n_flush * 256 * 10;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_bit("cpu_ready_o", 1'b0, cpu_ready_o);
        check_bit("mem_req_o", 1'b0, mem_req_o);
        check_bit("mem_we_o", 1'b0, mem_we_o);
        check_bit("flush_done_o", 1'b0, flush_done_o);
        for (i = 0; i < op_q.size(); i++)
        begin
            case (op_q[i])
                "R": do_access(1'b0, addr_q[i], data_q[i]);
                "W": do_access(1'b1, addr_q[i], data_q[i]);
                "F": do_flush();
                default: abort_run($sformatf("Unknown operation %c in case %0d", op_q[i], i));
            endcase
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verilog/cache_cmd_if.sv ====
`timescale 1ns/10ps

interface cache_cmd_if;

    // Strobes from the controller, at most one per cycle
    logic wr_en;         // Store the processor word, mark line dirty
    logic rd_en;         // Drive the selected word to the processor
    logic mem_wr;        // Write-back accepted by memory, clear dirty bit
    logic mem_rd;        // Load returned line and tag, set valid
    logic flush_step;    // Start or advance the flush walk
    logic flush_clear;   // End of walk, invalidate everything

    // Status from the datapath
    logic hit;
    logic dirty;         // Flush line while walking, else the request line
    logic flush_last;    // Walk sits on the final index

    modport ctrl (
        output wr_en, rd_en, mem_wr, mem_rd, flush_step, flush_clear,
        input  hit, dirty, flush_last
    );

    modport dp (
        input  wr_en, rd_en, mem_wr, mem_rd, flush_step, flush_clear,
        output hit, dirty, flush_last
    );

endinterface

// ==== verilog/cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    cache_cmd_if.ctrl  cmd,
    input  logic       cpu_req_i,
    input  logic       cpu_we_i,
    input  logic       flush_req_i,
    input  logic       mem_ack_i,
    output logic       cpu_ready_o,
    output logic       flush_done_o,
    output logic       mem_req_o,
    output logic       mem_we_o
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d         = state_q;
        cmd.wr_en       = 1'b0;
        cmd.rd_en       = 1'b0;
        cmd.mem_wr      = 1'b0;
        cmd.mem_rd      = 1'b0;
        cmd.flush_step  = 1'b0;
        cmd.flush_clear = 1'b0;

        case (state_q)
            IDLE:
            begin
                // Flush wins, it is only a one-cycle pulse while the
                // processor keeps its request held
                if (flush_req_i)
                begin
                    cmd.flush_step = 1'b1;   // Walk begins at line 0
                    state_d        = FLUSH_SCAN;
                end
                else if (cpu_req_i)
                begin
                    state_d = COMPARE;
                end
            end

            COMPARE:
            begin
                if (cmd.hit)
                    state_d = RESPOND;
                else if (cmd.dirty)
                    state_d = WRITEBACK;   // Victim first
                else
                    state_d = REFILL;
            end

            WRITEBACK:
            begin
                if (mem_ack_i)
                begin
                    cmd.mem_wr = 1'b1;
                    state_d    = COMPARE;  // Line now clean, lookup again
                end
            end

            REFILL:
            begin
                if (mem_ack_i)
                begin
                    cmd.mem_rd = 1'b1;     // Data valid with the ack
                    state_d    = RESPOND;
                end
            end

            RESPOND:
            begin
                // Write merge lands at the end of the ready cycle
                if (cpu_we_i)
                    cmd.wr_en = 1'b1;
                else
                    cmd.rd_en = 1'b1;
                state_d = IDLE;
            end

            FLUSH_SCAN:
            begin
                if (cmd.dirty)
                begin
                    state_d = FLUSH_WB;
                end
                else if (cmd.flush_last)
                begin
                    cmd.flush_clear = 1'b1;
                    state_d         = FLUSH_DONE;
                end
                else
                begin
                    cmd.flush_step = 1'b1;   // Next index, stay here
                end
            end

            FLUSH_WB:
            begin
                if (mem_ack_i)
                begin
                    cmd.mem_wr = 1'b1;
                    state_d    = FLUSH_SCAN; // Rescan sees it clean
                end
            end

            FLUSH_DONE:
                state_d = IDLE;

            default:
                state_d = IDLE;
        endcase
    end

    assign cpu_ready_o  = (state_q == RESPOND);
    assign flush_done_o = (state_q == FLUSH_DONE);

    // Request level held for the whole memory phase
    assign mem_req_o = (state_q == WRITEBACK) || (state_q == REFILL) ||
                       (state_q == FLUSH_WB);
    assign mem_we_o  = (state_q == WRITEBACK) || (state_q == FLUSH_WB);

endmodule

// ==== verilog/cache_datapath.sv ====
`timescale 1ns/10ps

module cache_datapath
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    cache_cmd_if.dp  cmd,
    input  addr_t    cpu_addr_i,
    input  word_t    cpu_wdata_i,
    input  line_t    mem_rdata_i,
    output word_t    cpu_rdata_o,
    output addr_t    mem_addr_o,
    output line_t    mem_wdata_o
);

    line_t line_mem [0:LINES-1];   // Data array
    tag_t  tag_mem  [0:LINES-1];   // Tag array

    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    // Request address fields
    tag_t        req_tag;
    index_t      req_idx;
    logic [1:0]  word_sel;

    // Flush walk
    logic        flush_on_q;
    index_t      flush_idx_q;

    index_t      sel_idx;          // Line under consideration
    addr_t       victim_addr;
    addr_t       refill_addr;
    addr_t       mem_addr_d;

    assign req_tag  = cpu_addr_i[ADDR_W-1 -: TAG_W];
    assign req_idx  = cpu_addr_i[OFFSET_W +: INDEX_W];
    assign word_sel = cpu_addr_i[OFFSET_W-1:2];

    // The walk takes over the line select while a flush runs
    assign sel_idx = flush_on_q ? flush_idx_q : req_idx;

    assign cmd.hit        = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
    assign cmd.dirty      = dirty_q[sel_idx];
    assign cmd.flush_last = flush_on_q && (flush_idx_q == index_t'(LINES - 1));

    // Old line goes back under its own stored tag
    assign victim_addr = {tag_mem[sel_idx], sel_idx, {OFFSET_W{1'b0}}};
    assign refill_addr = {req_tag, req_idx, {OFFSET_W{1'b0}}};

    always_comb
    begin
        if (flush_on_q || dirty_q[sel_idx])
            mem_addr_d = victim_addr;
        else
            mem_addr_d = refill_addr;
    end

    // Selected word only while the controller asks for it
    always_comb
    begin
        if (cmd.rd_en)
            cpu_rdata_o = line_mem[req_idx][word_sel*WORD_W +: WORD_W];
        else
            cpu_rdata_o = '0;
    end

    // Memory side registers, loaded every cycle and stable while the
    // request is held since address and line select do not move then
    always_ff @(posedge clk)
    begin
        mem_addr_o  <= mem_addr_d;
        mem_wdata_o <= line_mem[sel_idx];
    end

    // Data and tag storage
    always_ff @(posedge clk)
    begin
        if (cmd.mem_rd)
        begin
            line_mem[req_idx] <= mem_rdata_i;   // Whole line from memory
            tag_mem[req_idx]  <= req_tag;
        end
        else if (cmd.wr_en)
        begin
            line_mem[req_idx][word_sel*WORD_W +: WORD_W] <= cpu_wdata_i;
        end
    end

    // Per-line state and the flush walk
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid_q     <= '0;
            dirty_q     <= '0;
            flush_on_q  <= 1'b0;
            flush_idx_q <= '0;
        end
        else if (cmd.flush_clear)
        begin
            valid_q     <= '0;
            dirty_q     <= '0;   // All written back by now
            flush_on_q  <= 1'b0;
            flush_idx_q <= '0;
        end
        else
        begin
            if (cmd.mem_rd)
            begin
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= 1'b0;
            end
            else if (cmd.wr_en)
            begin
                dirty_q[req_idx] <= 1'b1;
            end
            else if (cmd.mem_wr)
            begin
                dirty_q[sel_idx] <= 1'b0;   // Victim now in memory
            end

            // First step only opens the walk at index 0
            if (cmd.flush_step)
            begin
                flush_on_q <= 1'b1;
                if (flush_on_q)
                    flush_idx_q <= flush_idx_q + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // Address and storage geometry
    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int LINE_W   = 128;   // 16 bytes per line
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int LINES    = 256;   // 4 KB total

    // Byte address from the processor
    typedef logic [ADDR_W-1:0] addr_t;

    // One processor word
    typedef logic [WORD_W-1:0] word_t;

    // One full cache line, also the memory transfer unit
    typedef logic [LINE_W-1:0] line_t;

    // Upper address bits kept per line
    typedef logic [TAG_W-1:0] tag_t;

    // Line index, address bits 11 to 4
    typedef logic [INDEX_W-1:0] index_t;

    // Bits 3 to 2 of the address select the word inside a line

    // Controller sequencing
    typedef enum logic [2:0] {
        IDLE,         // Waiting for an access or a flush
        COMPARE,      // Tag lookup
        WRITEBACK,    // Dirty victim goes out to memory
        REFILL,       // Line fetch from memory
        RESPOND,      // Word read or write, ready pulse
        FLUSH_SCAN,   // Look at one line of the flush walk
        FLUSH_WB,     // Dirty flush line goes out to memory
        FLUSH_DONE    // Done pulse
    } ctrl_state_t;

endpackage

// ==== verilog/cache_top.sv ====
`timescale 1ns/10ps

module cache_top
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // Processor port
    input  logic   cpu_req_i,
    input  logic   cpu_we_i,
    input  addr_t  cpu_addr_i,
    input  word_t  cpu_wdata_i,
    output word_t  cpu_rdata_o,
    output logic   cpu_ready_o,

    // Flush
    input  logic   flush_req_i,
    output logic   flush_done_o,

    // Main memory port, one line per transfer
    output logic   mem_req_o,
    output logic   mem_we_o,
    output addr_t  mem_addr_o,
    output line_t  mem_wdata_o,
    input  line_t  mem_rdata_i,
    input  logic   mem_ack_i
);

    cache_cmd_if cmd_bus ();   // Controller to datapath

    cache_controller ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd_bus.ctrl),
        .cpu_req_i    (cpu_req_i),
        .cpu_we_i     (cpu_we_i),
        .flush_req_i  (flush_req_i),
        .mem_ack_i    (mem_ack_i),
        .cpu_ready_o  (cpu_ready_o),
        .flush_done_o (flush_done_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o)
    );

    cache_datapath dp_i (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd_bus.dp),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .mem_rdata_i  (mem_rdata_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o)
    );

endmodule
